// ==== Bender.yml ====
package:
  name: singleCycle

sources:
  - src/mipsPkg.sv
  - src/decoder.sv
  - src/alu.sv
  - src/regFile.sv
  - src/wordMem.sv
  - src/singleCycle.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/isaChecker.sv
      - test/singleCycle_chk.sv
      - test/singleCycleTb.sv

// ==== singleCycle.f ====
src/mipsPkg.sv
src/decoder.sv
src/alu.sv
src/regFile.sv
src/wordMem.sv
src/singleCycle.sv
test/clockGen.sv
test/isaChecker.sv
test/singleCycle_chk.sv
test/singleCycleTb.sv

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu (
	input logic [mipsPkg::dataWidth-1:0] a,
	input logic [mipsPkg::dataWidth-1:0] b,
	input mipsPkg::aluOpT op,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic zero
);

	logic lessThan;

	// two's complement compare
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			mipsPkg::aluAnd: result = a & b;
			mipsPkg::aluOr: result = a | b;
			mipsPkg::aluAdd: result = a + b;
			mipsPkg::aluSub: result = a - b;
			mipsPkg::aluSlt: begin
				result = '0;
				result[0] = lessThan;	// 0 or 1
			end
			default: result = a;	// pass a
		endcase
	end

	// equality independent of op, beq only
	assign zero = (a == b);

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ns

module decoder (
	input mipsPkg::instrT instr,
	output mipsPkg::ctrlT ctrl
);

	always_comb begin
		ctrl = '0;					// unknown opcode leaves every flag off
		ctrl.aluOp = mipsPkg::aluPassA;
		case (instr.opcode)
			mipsPkg::opRtype: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				// alu control from funct
				case (instr.funct)
					mipsPkg::fnAdd: ctrl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub: ctrl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: ctrl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
					default: begin
						ctrl.regDst = 1'b0;	// unsupported funct is a no-op
						ctrl.regWrite = 1'b0;
					end
				endcase
			end
			mipsPkg::opAddi: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::aluAdd;
			end
			mipsPkg::opAndi: begin
				ctrl.aluSrc = 1'b1;		// immediate still sign extended
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::aluAnd;
			end
			mipsPkg::opLw: begin
				ctrl.aluSrc = 1'b1;		// base plus offset
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::aluAdd;
			end
			mipsPkg::opSw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluOp = mipsPkg::aluAdd;
			end
			mipsPkg::opBeq: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = mipsPkg::aluSub;	// zero flag decides
			end
			mipsPkg::opJ: begin
				ctrl.jump = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// ==== src/mipsPkg.sv ====
package mipsPkg;

	// machine and memory sizes
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;	// 32 registers
	localparam int memDepth = 64;		// words per memory
	localparam int memAddrWidth = 6;	// word index into either memory
	localparam int pcWidth = 8;		// byte pc, covers 64 words

	// primary opcodes
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// funct field for r-type
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	// alu operations
	typedef enum logic [2:0] {
		aluAnd = 3'd0,
		aluOr = 3'd1,
		aluAdd = 3'd2,
		aluSub = 3'd3,	// also the beq compare
		aluSlt = 3'd4,	// signed
		aluPassA = 3'd5
	} aluOpT;

	// instruction word, r-type layout
	// i-type immediate is {rd, shamt, funct}
	// j-type target is everything below opcode
	typedef struct packed {
		logic [5:0] opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instrT;

	// decoded control, one per instruction
	typedef struct packed {
		logic regDst;		// write rd instead of rt
		logic jump;
		logic branch;		// beq, taken on zero
		logic memToReg;		// write back load data
		logic memWrite;
		logic aluSrc;		// b operand is the immediate
		logic regWrite;
		aluOpT aluOp;
	} ctrlT;

endpackage

// ==== src/regFile.sv ====
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic reset,
	input logic [mipsPkg::regAddrWidth-1:0] readAddr1,
	input logic [mipsPkg::regAddrWidth-1:0] readAddr2,
	input logic [mipsPkg::regAddrWidth-1:0] writeAddr,
	input logic writeEn,
	input logic [mipsPkg::dataWidth-1:0] writeData,
	output logic [mipsPkg::dataWidth-1:0] readData1,
	output logic [mipsPkg::dataWidth-1:0] readData2
);

	logic [mipsPkg::dataWidth-1:0] regs [2**mipsPkg::regAddrWidth];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++)
				regs[i] <= '0;
		end else if (writeEn && writeAddr != '0) begin	// $0 is never written
			regs[writeAddr] <= writeData;
		end
	end

	// combinational reads, $0 forced to zero
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// ==== src/singleCycle.sv ====
`timescale 1ns/1ns

module singleCycle (
	input logic clk,
	input logic reset,
	input logic run,		// 1 executes, 0 pauses for load and inspect
	input logic [mipsPkg::regAddrWidth-1:0] regSelect,
	input logic loadEn,
	input logic [mipsPkg::memAddrWidth-1:0] loadAddr,
	input logic [mipsPkg::dataWidth-1:0] loadData,
	output logic [mipsPkg::dataWidth-1:0] regView,
	output logic [mipsPkg::pcWidth-1:0] pc
);

	mipsPkg::instrT instr;
	mipsPkg::ctrlT ctrl;

	logic [mipsPkg::memAddrWidth-1:0] instrAddr;
	logic [mipsPkg::regAddrWidth-1:0] readAddr1;
	logic [mipsPkg::regAddrWidth-1:0] writeAddr;
	logic [mipsPkg::dataWidth-1:0] readData1, readData2;
	logic [mipsPkg::dataWidth-1:0] writeData;
	logic [mipsPkg::dataWidth-1:0] immExt;
	logic [mipsPkg::dataWidth-1:0] aluB, aluResult;
	logic [mipsPkg::dataWidth-1:0] memReadData;
	logic [mipsPkg::dataWidth-1:0] pcPlus4, branchTarget, jumpTarget, nextPc;
	logic aluZero;

	// load port owns the instruction memory while paused
	assign instrAddr = run ? pc[mipsPkg::pcWidth-1:2] : loadAddr;

	wordMem #(.depth(mipsPkg::memDepth), .clearOnReset(1'b0)) instrMem (
		.clk(clk),
		.reset(reset),
		.addr(instrAddr),
		.writeEn(loadEn & ~run),
		.writeData(loadData),
		.readData(instr)
	);

	decoder decoder_inst (.instr(instr), .ctrl(ctrl));

	// i-type immediate, sign extended for all of them
	assign immExt = {{16{instr.rd[4]}}, instr.rd, instr.shamt, instr.funct};

	// port 1 doubles as the inspect port
	assign readAddr1 = run ? instr.rs : regSelect;
	assign writeAddr = ctrl.regDst ? instr.rd : instr.rt;
	assign writeData = ctrl.memToReg ? memReadData : aluResult;

	regFile regFile_inst (
		.clk(clk),
		.reset(reset),
		.readAddr1(readAddr1),
		.readAddr2(instr.rt),
		.writeAddr(writeAddr),
		.writeEn(ctrl.regWrite & run),	// no writes while paused
		.writeData(writeData),
		.readData1(readData1),
		.readData2(readData2)
	);

	assign regView = readData1;
	assign aluB = ctrl.aluSrc ? immExt : readData2;

	alu alu_inst (
		.a(readData1),
		.b(aluB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	// word index from byte address bits 7..2
	wordMem #(.depth(mipsPkg::memDepth), .clearOnReset(1'b1)) dataMem (
		.clk(clk),
		.reset(reset),
		.addr(aluResult[mipsPkg::pcWidth-1:2]),
		.writeEn(ctrl.memWrite & run),
		.writeData(readData2),		// rt data
		.readData(memReadData)
	);

	// next pc, formed at full width then cut to pcWidth
	assign pcPlus4 = {{(mipsPkg::dataWidth - mipsPkg::pcWidth){1'b0}}, pc} + 32'd4;
	assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
	assign jumpTarget = {pcPlus4[31:28], instr.rs, instr.rt, instr.rd, instr.shamt,
		instr.funct, 2'b00};	// target field shifted left 2

	always_comb begin
		if (ctrl.jump)
			nextPc = jumpTarget;
		else if (ctrl.branch && aluZero)	// beq taken
			nextPc = branchTarget;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= '0;
		else if (run)		// holds while paused
			pc <= nextPc[mipsPkg::pcWidth-1:0];
	end

endmodule

// ==== src/wordMem.sv ====
`timescale 1ns/1ns

module wordMem #(
	parameter int depth = 64,
	parameter bit clearOnReset = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic [$clog2(depth)-1:0] addr,
	input logic writeEn,
	input logic [mipsPkg::dataWidth-1:0] writeData,
	output logic [mipsPkg::dataWidth-1:0] readData
);

	logic [mipsPkg::dataWidth-1:0] mem [depth];

	generate
		if (clearOnReset) begin : gClear
			// data memory, zeroed by reset
			always_ff @(posedge clk or posedge reset) begin
				if (reset) begin
					for (int i = 0; i < depth; i++)
						mem[i] <= '0;
				end else if (writeEn) begin
					mem[addr] <= writeData;
				end
			end
		end else begin : gKeep
			// contents survive reset, program stays loaded
			always_ff @(posedge clk) begin
				if (writeEn)
					mem[addr] <= writeData;
			end
		end
	endgenerate

	assign readData = mem[addr];	// async read

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/1ns

module clockGen (
	input logic resetReq,	// rising edge restarts the reset pulse
	output logic clk,
	output logic reset
);

	localparam int halfPeriod = 4;	// 8 ns clock
	localparam int resetCycles = 8;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// reset changes on falling edges, away from the sampling edge
	initial begin
		reset = 1'b1;
		forever begin
			repeat (resetCycles) @(negedge clk);
			reset = 1'b0;
			@(posedge resetReq);
			reset = 1'b1;
		end
	end

endmodule

// ==== test/isaChecker.sv ====
`timescale 1ns/1ns

// instruction-level model of the core, compared at every rising edge out of reset
module isaChecker (
	input logic clk,
	input logic reset,
	input logic run,
	input logic [mipsPkg::regAddrWidth-1:0] regSelect,
	input logic loadEn,
	input logic [mipsPkg::memAddrWidth-1:0] loadAddr,
	input logic [mipsPkg::dataWidth-1:0] loadData,
	input logic [mipsPkg::dataWidth-1:0] regView,
	input logic [mipsPkg::pcWidth-1:0] pc,
	output int errors
);

	logic [31:0] imem [mipsPkg::memDepth];	// mirror of the load strobes
	logic [31:0] dmem [mipsPkg::memDepth];
	logic [31:0] regs [2**mipsPkg::regAddrWidth];
	logic [7:0] modelPc;

	initial errors = 0;

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors = errors + 1;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// one instruction, pre-edge state in, post-edge state out
	task automatic step();
		logic [31:0] word;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] val;
		logic [4:0] dest;
		logic wr;
		word = imem[modelPc[7:2]];
		rsVal = regs[word[25:21]];
		rtVal = regs[word[20:16]];
		imm = 32'($signed(word[15:0]));	// every i-type sign extends
		addr = rsVal + imm;
		dest = word[20:16];	// i-type target is rt
		wr = 1'b1;
		val = '0;
		compare("rsView", rsVal, regView);	// port 1 tracks rs while running
		modelPc = modelPc + 8'd4;
		case (word[31:26])
			mipsPkg::opRtype: begin
				dest = word[15:11];
				case (word[5:0])
					mipsPkg::fnAdd: val = rsVal + rtVal;
					mipsPkg::fnSub: val = rsVal - rtVal;
					mipsPkg::fnAnd: val = rsVal & rtVal;
					mipsPkg::fnOr: val = rsVal | rtVal;
					mipsPkg::fnSlt: val = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;	// nop, the zero fill word lands here
				endcase
			end
			mipsPkg::opAddi: val = rsVal + imm;
			mipsPkg::opAndi: val = rsVal & imm;
			mipsPkg::opLw: val = dmem[addr[7:2]];	// word index
			mipsPkg::opSw: begin
				dmem[addr[7:2]] = rtVal;
				wr = 1'b0;
			end
			mipsPkg::opBeq: begin
				wr = 1'b0;
				if (rsVal == rtVal)
					modelPc = modelPc + 8'(imm << 2);	// offset from pc+4
			end
			mipsPkg::opJ: begin
				wr = 1'b0;
				modelPc = {word[5:0], 2'b00};	// 8-bit pc keeps 6 target bits
			end
			default: wr = 1'b0;
		endcase
		if (wr && dest != 5'd0)
			regs[dest] = val;	// $0 stays zero
	endtask

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++)
				regs[i] = '0;
			for (int i = 0; i < mipsPkg::memDepth; i++)
				dmem[i] = '0;
			modelPc = '0;
		end else if (run) begin
			compare("pcRun", {24'd0, modelPc}, {24'd0, pc});
			step();
		end else begin
			compare("pcHold", {24'd0, modelPc}, {24'd0, pc});
			compare("regInspect", regs[regSelect], regView);
		end
		// instruction memory keeps its words across reset
		if (loadEn && !run)
			imem[loadAddr] = loadData;
	end

endmodule

// ==== test/singleCycleTb.sv ====
`timescale 1ns/1ns

module singleCycleTb;

	localparam int numTrials = 12;
	localparam int resetTimeout = 40;	// cycles

	logic clk;
	logic reset;
	logic resetReq;
	logic run;
	logic [mipsPkg::regAddrWidth-1:0] regSelect;
	logic loadEn;
	logic [mipsPkg::memAddrWidth-1:0] loadAddr;
	logic [mipsPkg::dataWidth-1:0] loadData;
	logic [mipsPkg::dataWidth-1:0] regView;
	logic [mipsPkg::pcWidth-1:0] pc;
	int mismatches;
	int timeouts;

	clockGen clockGen_inst (.resetReq(resetReq), .clk(clk), .reset(reset));

	singleCycle singleCycle_inst (
		.clk(clk),
		.reset(reset),
		.run(run),
		.regSelect(regSelect),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.regView(regView),
		.pc(pc)
	);

	isaChecker isaChecker_inst (
		.clk(clk),
		.reset(reset),
		.run(run),
		.regSelect(regSelect),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.regView(regView),
		.pc(pc),
		.errors(mismatches)
	);

	// legal instruction at word idx, targets kept inside words 0..len-1
	function automatic logic [31:0] randomInstr(input int idx, input int len);
		mipsPkg::instrT ins;
		int kind;
		int target;
		logic [15:0] imm;
		ins = '0;
		ins.rs = 5'($urandom_range(31, 0));
		ins.rt = 5'($urandom_range(31, 0));
		imm = 16'($urandom());
		target = $urandom_range(len - 1, 0);
		kind = $urandom_range(12, 0);
		if (kind <= 4) begin
			ins.opcode = mipsPkg::opRtype;
			ins.rd = 5'($urandom_range(31, 0));
			case (kind)
				0: ins.funct = mipsPkg::fnAdd;
				1: ins.funct = mipsPkg::fnSub;
				2: ins.funct = mipsPkg::fnAnd;
				3: ins.funct = mipsPkg::fnOr;
				default: ins.funct = mipsPkg::fnSlt;
			endcase
			return ins;
		end
		case (kind)
			5, 6: ins.opcode = mipsPkg::opAddi;
			7: ins.opcode = mipsPkg::opAndi;
			8: ins.opcode = mipsPkg::opLw;
			9, 10: ins.opcode = mipsPkg::opSw;
			11: ins.opcode = mipsPkg::opBeq;
			default: ins.opcode = mipsPkg::opJ;
		endcase
		if (kind == 11)
			imm = 16'(target - idx - 1);	// word offset from the next pc
		else if (kind >= 8 && kind <= 10)
			imm = {8'd0, 6'($urandom_range(63, 0)), 2'b00};	// aligned, 0..252
		{ins.rd, ins.shamt, ins.funct} = imm;
		if (kind == 12)
			{ins.rs, ins.rt, ins.rd, ins.shamt, ins.funct} = 26'(target);
		return ins;
	endfunction

	task automatic waitForReset(input logic level);
		int n;
		n = 0;
		while (reset !== level && n < resetTimeout) begin
			@(negedge clk);
			n++;
		end
		if (reset !== level) begin
			timeouts++;
			$display("reset did not go to %0d within %0d cycles", level, resetTimeout);
		end
	endtask

	task automatic applyReset();
		@(negedge clk);
		resetReq = 1'b1;
		waitForReset(1'b1);
		resetReq = 1'b0;
		waitForReset(1'b0);
	endtask

	// one register per cycle, compared at the next rising edge
	task automatic sweepRegs();
		for (int r = 0; r < 2**mipsPkg::regAddrWidth; r++) begin
			@(negedge clk);
			regSelect = r[mipsPkg::regAddrWidth-1:0];
		end
	endtask

	task automatic loadProgram(input int len);
		for (int i = 0; i < mipsPkg::memDepth; i++) begin
			@(negedge clk);
			loadEn = 1'b1;
			loadAddr = i[mipsPkg::memAddrWidth-1:0];
			loadData = (i < len) ? randomInstr(i, len) : '0;	// zero fill past the program
		end
		@(negedge clk);
		loadEn = 1'b0;
	endtask

	task automatic holdPaused();
		repeat ($urandom_range(12, 3)) begin
			@(negedge clk);
			regSelect = 5'($urandom_range(31, 0));
		end
	endtask

	task automatic runFor(input int cycles);
		@(negedge clk);
		run = 1'b1;
		repeat (cycles) @(negedge clk);
		run = 1'b0;
	endtask

	initial begin
		int len;
		int assertFails;
		void'($urandom(32'he534_0a30));
		timeouts = 0;
		resetReq = 1'b0;
		run = 1'b0;
		regSelect = '0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		for (int t = 0; t < numTrials; t++) begin
			applyReset();
			sweepRegs();	// everything zero before the first run
			len = $urandom_range(32, 8);
			loadProgram(len);
			holdPaused();
			sweepRegs();
			runFor($urandom_range(160, 20));
			sweepRegs();
			holdPaused();	// paused cycles must leave state alone
			sweepRegs();
		end
		@(negedge clk);
		@(negedge clk);
		assertFails = singleCycle_inst.chkInst.failures;
		$display("mismatches %0d, timeouts %0d, assertion failures %0d",
			mismatches, timeouts, assertFails);
		if (mismatches == 0 && timeouts == 0 && assertFails == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== test/singleCycle_chk.sv ====
`timescale 1ns/1ns

module singleCycle_chk (
	input logic clk,
	input logic reset,
	input logic run,
	input logic [mipsPkg::regAddrWidth-1:0] regSelect,
	input logic [mipsPkg::dataWidth-1:0] regView,
	input logic [mipsPkg::pcWidth-1:0] pc
);

	int failures = 0;	// failed assertions so far

	pcHeld: assert property (@(posedge clk) disable iff (reset) !run |=> $stable(pc))
		else begin
			failures++;
			$error("pc changed while run was low");
		end

	pcAligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
		else begin
			failures++;
			$error("pc is not word aligned");
		end

	zeroView: assert property (@(posedge clk) disable iff (reset)
		(!run && regSelect == '0) |-> regView == '0)
		else begin
			failures++;
			$error("register 0 read back nonzero");
		end

	// a paused edge must not change the register on view
	noPausedWrite: assert property (@(posedge clk) disable iff (reset)
		(!run && $past(!run) && $stable(regSelect)) |-> $stable(regView))
		else begin
			failures++;
			$error("register changed while run was low");
		end

endmodule

bind singleCycle singleCycle_chk chkInst (
	.clk(clk),
	.reset(reset),
	.run(run),
	.regSelect(regSelect),
	.regView(regView),
	.pc(pc)
);
